// ==== Bender.yml ====
package:
  name: pkt_stats

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - pkt_stats_pkg.sv
      - pkt_event_counters.sv
      - csr_host_port.sv
      - csr_bus_arbiter.sv
      - pkt_stats_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - pkt_stats_assert.sv
      - pkt_stats_tb.sv

// ==== csr_bus_arbiter.sv ====
// two-way round-robin arbiter driving the shared register bus
`timescale 1ns/1ns

module csr_bus_arbiter
	import pkt_stats_pkg::*;
#(
	parameter int DATA_W = 32
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              req_mgmt,
	input  logic              req_dbg,
	input  csr_op_e           op_mgmt,
	input  csr_op_e           op_dbg,
	input  cnt_addr_e         addr_mgmt,
	input  cnt_addr_e         addr_dbg,
	input  logic [DATA_W-1:0] wdata_mgmt,
	input  logic [DATA_W-1:0] wdata_dbg,
	output logic              gnt_mgmt,
	output logic              gnt_dbg,
	output logic              cmd_valid,
	output csr_op_e           cmd_op,
	output cnt_addr_e         cmd_addr,
	output logic [DATA_W-1:0] cmd_wdata
);

	// set when debug was served last, so management wins the next tie
	logic last_dbg;

	assign gnt_mgmt  = req_mgmt && (!req_dbg || last_dbg);
	assign gnt_dbg   = req_dbg && !gnt_mgmt;
	assign cmd_valid = gnt_mgmt || gnt_dbg;

	// command mux, management port by default
	assign cmd_op    = gnt_dbg ? op_dbg    : op_mgmt;
	assign cmd_addr  = gnt_dbg ? addr_dbg  : addr_mgmt;
	assign cmd_wdata = gnt_dbg ? wdata_dbg : wdata_mgmt;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last_dbg <= 1'b1;
		end else if (cmd_valid) begin
			last_dbg <= gnt_dbg;
		end
	end

endmodule

// ==== csr_host_port.sv ====
// four-phase req/ack host port, one host transaction per bus request
`timescale 1ns/1ns

module csr_host_port
	import pkt_stats_pkg::*;
#(
	parameter int DATA_W = 32
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              h_req,
	input  csr_op_e           h_op,
	input  cnt_addr_e         h_addr,
	input  logic [DATA_W-1:0] h_wdata,
	output logic              h_ack,
	output logic [DATA_W-1:0] h_rdata,
	output logic              bus_req,
	output csr_op_e           bus_op,
	output cnt_addr_e         bus_addr,
	output logic [DATA_W-1:0] bus_wdata,
	input  logic              bus_gnt,
	input  logic [DATA_W-1:0] rd_data
);

	hs_state_e state;
	hs_state_e state_nxt;
	logic      accept;

	// a new request only once the previous ack has gone
	assign accept  = (state == hs_idle) && h_req && !h_ack;
	assign bus_req = (state == hs_wait_grant);

	always_comb begin
		state_nxt = state;
		case (state)
			hs_idle: begin
				if (accept) begin
					state_nxt = hs_wait_grant;
				end
			end
			hs_wait_grant: begin
				if (bus_gnt) begin
					state_nxt = hs_wait_data;
				end
			end
			hs_wait_data: begin
				state_nxt = hs_ack;
			end
			hs_ack: begin
				if (!h_req) begin
					state_nxt = hs_idle;
				end
			end
			default: begin
				state_nxt = hs_idle;
			end
		endcase
	end

	// ack trails the state by one cycle, so it also falls one cycle late
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= hs_idle;
			h_ack <= 1'b0;
		end else begin
			state <= state_nxt;
			h_ack <= (state == hs_ack);
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			bus_op    <= h_op;
			bus_addr  <= h_addr;
			bus_wdata <= h_wdata;
		end
		// bank answers the cycle after the grant
		if (state == hs_wait_data) begin
			h_rdata <= rd_data;
		end
	end

endmodule

// ==== pkt_event_counters.sv ====
// packet event counter bank: lane sums, 64-bit saturating counters,
// register writes, snapshot shadows and registered read data
`timescale 1ns/1ns
`include "pkt_stats_params.svh"

module pkt_event_counters
	import pkt_stats_pkg::*;
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     tx_sop,
	input  logic                     tx_eop,
	input  logic                     tx_pkt,
	input  logic [`NUM_RX_LANES-1:0] rx_sop,
	input  logic [`NUM_RX_LANES-1:0] rx_eop,
	input  logic [`NUM_RX_LANES-1:0] rx_pkt,
	input  logic [`NUM_RX_LANES-1:0] rx_crc_ok,
	input  logic [`NUM_RX_LANES-1:0] rx_crc_err,
	input  logic                     cmd_valid,
	input  csr_op_e                  cmd_op,
	input  cnt_addr_e                cmd_addr,
	input  logic [`CSR_DATA_W-1:0]   cmd_wdata,
	output logic [`CSR_DATA_W-1:0]   rd_data
);

	localparam int LANES   = `NUM_RX_LANES;
	localparam int SUM_W   = `LANE_SUM_W;
	localparam int DW      = `CSR_DATA_W;
	localparam int IDX_W   = `CSR_ADDR_W - 1;
	localparam int NUM_CNT = 2 ** IDX_W;

	logic [LANES-1:0]  ev_bits [NUM_CNT];
	logic [SUM_W-1:0]  ev_sum  [NUM_CNT];
	logic [DW-1:0]     cnt_lo  [NUM_CNT];
	logic [DW-1:0]     cnt_hi  [NUM_CNT];
	logic [2*DW-1:0]   cnt_inc [NUM_CNT];
	logic [DW-1:0]     shd_lo  [NUM_CNT];
	logic [DW-1:0]     shd_hi  [NUM_CNT];
	logic              cmd_hi;
	logic [IDX_W-1:0]  cmd_idx;
	logic              wr_en;
	logic              snap_en;

	// number of set bits in one cycle's lane vector
	function automatic logic [SUM_W-1:0] lane_sum(input logic [LANES-1:0] bits);
		logic [SUM_W-1:0] acc;
		acc = '0;
		for (int i = 0; i < LANES; i++) begin
			acc = acc + SUM_W'(bits[i]);
		end
		return acc;
	endfunction

	// low half carries into high half, stick at all ones on overflow
	function automatic logic [2*DW-1:0] sat_add(
		input logic [DW-1:0]    hi,
		input logic [DW-1:0]    lo,
		input logic [SUM_W-1:0] inc
	);
		logic [DW:0] lo_sum;
		logic [DW:0] hi_sum;
		lo_sum = {1'b0, lo} + (DW + 1)'(inc);
		hi_sum = {1'b0, hi} + (DW + 1)'(lo_sum[DW]);
		return hi_sum[DW] ? '1 : {hi_sum[DW-1:0], lo_sum[DW-1:0]};
	endfunction

	assign cmd_hi  = cmd_addr[`CSR_ADDR_W-1];
	assign cmd_idx = cmd_addr[IDX_W-1:0];
	assign wr_en   = cmd_valid && (cmd_op == op_write);
	assign snap_en = cmd_valid && (cmd_op == op_snapshot);

	// ------------------------------------------------------------------------
	// event inputs in register address order, tx zero-extended
	// ------------------------------------------------------------------------
	always_comb begin
		ev_bits[0] = LANES'(tx_sop);
		ev_bits[1] = LANES'(tx_eop);
		ev_bits[2] = LANES'(tx_pkt);
		ev_bits[3] = rx_sop;
		ev_bits[4] = rx_eop;
		ev_bits[5] = rx_pkt;
		ev_bits[6] = rx_crc_ok;
		ev_bits[7] = rx_crc_err;
	end

	// first stage: registered lane popcounts
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ev_sum <= '{default: '0};
		end else begin
			for (int i = 0; i < NUM_CNT; i++) begin
				ev_sum[i] <= lane_sum(ev_bits[i]);
			end
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_CNT; i++) begin
			cnt_inc[i] = sat_add(cnt_hi[i], cnt_lo[i], ev_sum[i]);
		end
	end

	// ------------------------------------------------------------------------
	// second stage: live counters
	// ------------------------------------------------------------------------
	// a write loads only the addressed half and drops that cycle's increment
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt_lo <= '{default: '0};
			cnt_hi <= '{default: '0};
		end else begin
			for (int i = 0; i < NUM_CNT; i++) begin
				if (wr_en && (cmd_idx == IDX_W'(i))) begin
					if (cmd_hi) begin
						cnt_hi[i] <= cmd_wdata;
					end else begin
						cnt_lo[i] <= cmd_wdata;
					end
				end else begin
					{cnt_hi[i], cnt_lo[i]} <= cnt_inc[i];
				end
			end
		end
	end

	// all counters captured at the same edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			shd_lo <= '{default: '0};
			shd_hi <= '{default: '0};
		end else if (snap_en) begin
			shd_lo <= cnt_lo;
			shd_hi <= cnt_hi;
		end
	end

	// read data follows cmd_valid by one cycle
	always_ff @(posedge clk) begin
		if (cmd_valid) begin
			rd_data <= cmd_hi ? shd_hi[cmd_idx] : shd_lo[cmd_idx];
		end
	end

endmodule

// ==== pkt_stats_assert.sv ====
// host handshake and bus arbitration assertions, bound into the top level
`timescale 1ns/1ns

module pkt_stats_assert (
	input logic clk,
	input logic arst_n,
	input logic mgmt_req,
	input logic mgmt_ack,
	input logic dbg_req,
	input logic dbg_ack,
	input logic gnt_mgmt,
	input logic gnt_dbg
);

	// ack only rises against a live request
	assert property (@(posedge clk) disable iff (!arst_n) $rose(mgmt_ack) |-> mgmt_req)
		else $error("management ack rose without a request");
	assert property (@(posedge clk) disable iff (!arst_n) $rose(dbg_ack) |-> dbg_req)
		else $error("debug ack rose without a request");

	// ack held while the host keeps req high
	assert property (@(posedge clk) disable iff (!arst_n) mgmt_ack && mgmt_req |=> mgmt_ack)
		else $error("management ack dropped before the request");
	assert property (@(posedge clk) disable iff (!arst_n) dbg_ack && dbg_req |=> dbg_ack)
		else $error("debug ack dropped before the request");

	assert property (@(posedge clk) disable iff (!arst_n) !(gnt_mgmt && gnt_dbg))
		else $error("both host ports granted in one cycle");

	assert property (@(posedge clk) $rose(arst_n) |-> !mgmt_ack && !dbg_ack)
		else $error("ack high right after reset release");

endmodule

bind pkt_stats_top pkt_stats_assert u_assert (
	.clk      (clk),
	.arst_n   (arst_n),
	.mgmt_req (mgmt_req),
	.mgmt_ack (mgmt_ack),
	.dbg_req  (dbg_req),
	.dbg_ack  (dbg_ack),
	.gnt_mgmt (gnt_mgmt),
	.gnt_dbg  (gnt_dbg)
);

// ==== pkt_stats_params.svh ====
// sizing macros for the packet statistics block
// lane count, register bus widths and testbench run length
`ifndef PKT_STATS_PARAMS_SVH
`define PKT_STATS_PARAMS_SVH

// ---------------------------------------------------------------------------
// receive side
// ---------------------------------------------------------------------------
// number of receive checker lanes
`define NUM_RX_LANES 4
// bits needed to hold one cycle's lane sum, 0 .. NUM_RX_LANES
`define LANE_SUM_W ($clog2(`NUM_RX_LANES + 1))

// ---------------------------------------------------------------------------
// register bus
// ---------------------------------------------------------------------------
`define CSR_DATA_W 32
// msb selects the high word, the rest selects the counter
`define CSR_ADDR_W 4

// ---------------------------------------------------------------------------
// testbench timeout: rows * cycles per row + margin
// ---------------------------------------------------------------------------
`define TB_CYCLES_PER_ROW 40
`define TB_TIMEOUT_MARGIN 100

`endif

// ==== pkt_stats_pkg.sv ====
// register bus operations, counter register addresses and host port states
package pkt_stats_pkg;

	// operations carried on the shared register bus
	typedef enum logic [1:0] {
		op_read     = 2'd0,
		op_write    = 2'd1,
		op_snapshot = 2'd2
	} csr_op_e;

	// low words first, high words at the same offset plus 8
	typedef enum logic [3:0] {
		addr_tx_sop_lo     = 4'd0,
		addr_tx_eop_lo     = 4'd1,
		addr_tx_pkt_lo     = 4'd2,
		addr_rx_sop_lo     = 4'd3,
		addr_rx_eop_lo     = 4'd4,
		addr_rx_pkt_lo     = 4'd5,
		addr_rx_crc_ok_lo  = 4'd6,
		addr_rx_crc_err_lo = 4'd7,
		addr_tx_sop_hi     = 4'd8,
		addr_tx_eop_hi     = 4'd9,
		addr_tx_pkt_hi     = 4'd10,
		addr_rx_sop_hi     = 4'd11,
		addr_rx_eop_hi     = 4'd12,
		addr_rx_pkt_hi     = 4'd13,
		addr_rx_crc_ok_hi  = 4'd14,
		addr_rx_crc_err_hi = 4'd15
	} cnt_addr_e;

	// four-phase host handshake
	typedef enum logic [1:0] {
		hs_idle       = 2'd0,
		hs_wait_grant = 2'd1,
		hs_wait_data  = 2'd2,
		hs_ack        = 2'd3
	} hs_state_e;

endpackage

// ==== pkt_stats_tb.sv ====
// testbench for the packet statistics block: table of host transactions,
// random rx lane events, a counter model and a shared bus read
`timescale 1ns/1ns
`include "pkt_stats_params.svh"

module pkt_stats_tb
	import pkt_stats_pkg::*;
();

	typedef struct packed {
		bit                     host;
		csr_op_e                op;
		cnt_addr_e              addr;
		logic [`CSR_DATA_W-1:0] wdata;
		logic [7:0]             n_tx;
		logic [7:0]             n_rx;
		logic [`CSR_DATA_W-1:0] exp;
		bit                     use_model;
		bit                     sweep;
	} row_t;

	logic                     clk = 1'b0;
	logic                     arst_n;
	logic                     mgmt_req;
	csr_op_e                  mgmt_op;
	cnt_addr_e                mgmt_addr;
	logic [`CSR_DATA_W-1:0]   mgmt_wdata;
	logic                     mgmt_ack;
	logic [`CSR_DATA_W-1:0]   mgmt_rdata;
	logic                     dbg_req;
	csr_op_e                  dbg_op;
	cnt_addr_e                dbg_addr;
	logic [`CSR_DATA_W-1:0]   dbg_wdata;
	logic                     dbg_ack;
	logic [`CSR_DATA_W-1:0]   dbg_rdata;
	logic                     tx_sop;
	logic                     tx_eop;
	logic                     tx_pkt;
	logic [`NUM_RX_LANES-1:0] rx_sop;
	logic [`NUM_RX_LANES-1:0] rx_eop;
	logic [`NUM_RX_LANES-1:0] rx_pkt;
	logic [`NUM_RX_LANES-1:0] rx_crc_ok;
	logic [`NUM_RX_LANES-1:0] rx_crc_err;

	row_t        rows[$];
	logic [63:0] live   [8];
	logic [63:0] shadow [8];
	integer      seed = 33;
	int          errors = 0;
	int          cycles = 0;
	int          cycle_limit = 1000;

	pkt_stats_top u_dut (.*);

	always #50 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: no result after %0d clock cycles", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// counter model: 64-bit sum of set bits, sticks at all ones
	// ------------------------------------------------------------------------
	function automatic void model_add(input int idx, input int n);
		logic [64:0] sum;
		sum = {1'b0, live[idx]} + 65'(n);
		live[idx] = sum[64] ? '1 : sum[63:0];
	endfunction

	// a write replaces only the addressed half
	function automatic void model_write(input cnt_addr_e addr, input logic [31:0] data);
		logic [3:0] a;
		a = addr;
		if (a[3]) begin
			live[a[2:0]][63:32] = data;
		end else begin
			live[a[2:0]][31:0] = data;
		end
	endfunction

	function automatic logic [31:0] shadow_word(input cnt_addr_e addr);
		logic [3:0] a;
		a = addr;
		return a[3] ? shadow[a[2:0]][63:32] : shadow[a[2:0]][31:0];
	endfunction

	task automatic add_row(input bit host, input csr_op_e op, input cnt_addr_e addr,
		input logic [31:0] wdata, input int n_tx, input int n_rx,
		input logic [31:0] exp, input bit use_model, input bit sweep);
		row_t r;
		r = '{host, op, addr, wdata, 8'(n_tx), 8'(n_rx), exp, use_model, sweep};
		rows.push_back(r);
	endtask

	task automatic check_word(input cnt_addr_e addr, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t ns: register %0d read %h, expected %h", $time, addr, got, exp);
		end
	endtask

	// tx events on all three tx inputs, then random rx lane masks
	task automatic drive_events(input int n_tx, input int n_rx);
		logic [31:0]              rnd;
		logic [`NUM_RX_LANES-1:0] m [5];
		for (int c = 0; c < n_tx; c++) begin
			@(posedge clk);
			tx_sop <= 1'b1;
			tx_eop <= 1'b1;
			tx_pkt <= 1'b1;
			for (int i = 0; i < 3; i++) begin
				model_add(i, 1);
			end
		end
		for (int c = 0; c < n_rx; c++) begin
			for (int k = 0; k < 5; k++) begin
				rnd = $random(seed);
				m[k] = rnd[`NUM_RX_LANES-1:0];
				model_add(3 + k, $countones(m[k]));
			end
			@(posedge clk);
			{tx_sop, tx_eop, tx_pkt} <= 3'b000;
			rx_sop     <= m[0];
			rx_eop     <= m[1];
			rx_pkt     <= m[2];
			rx_crc_ok  <= m[3];
			rx_crc_err <= m[4];
		end
		@(posedge clk);
		{tx_sop, tx_eop, tx_pkt} <= 3'b000;
		{rx_sop, rx_eop, rx_pkt, rx_crc_ok, rx_crc_err} <= '0;
		repeat (4) @(posedge clk);
	endtask

	// one four-phase transaction on the selected host
	task automatic run_transaction(input bit host, input csr_op_e op, input cnt_addr_e addr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		@(posedge clk);
		if (host) begin
			dbg_req   <= 1'b1;
			dbg_op    <= op;
			dbg_addr  <= addr;
			dbg_wdata <= wdata;
		end else begin
			mgmt_req   <= 1'b1;
			mgmt_op    <= op;
			mgmt_addr  <= addr;
			mgmt_wdata <= wdata;
		end
		do @(negedge clk); while (!(host ? dbg_ack : mgmt_ack));
		rdata = host ? dbg_rdata : mgmt_rdata;
		@(posedge clk);
		if (host) begin
			dbg_req <= 1'b0;
		end else begin
			mgmt_req <= 1'b0;
		end
		do @(negedge clk); while (host ? dbg_ack : mgmt_ack);
	endtask

	// both hosts request in the same cycle, completion order is free
	task automatic dual_read(input cnt_addr_e addr_m, input cnt_addr_e addr_d);
		@(posedge clk);
		mgmt_req  <= 1'b1;
		mgmt_op   <= op_read;
		mgmt_addr <= addr_m;
		dbg_req   <= 1'b1;
		dbg_op    <= op_read;
		dbg_addr  <= addr_d;
		do @(negedge clk); while (!(mgmt_ack && dbg_ack));
		check_word(addr_m, mgmt_rdata, shadow_word(addr_m));
		check_word(addr_d, dbg_rdata, shadow_word(addr_d));
		@(posedge clk);
		mgmt_req <= 1'b0;
		dbg_req  <= 1'b0;
		do @(negedge clk); while (mgmt_ack || dbg_ack);
	endtask

	// ------------------------------------------------------------------------
	// stimulus table: host, op, addr, wdata, tx, rx cycles, exp, model, sweep
	// ------------------------------------------------------------------------
	task automatic build_table();
		// reset values
		add_row(0, op_snapshot, addr_tx_sop_lo, 32'h0, 0, 0, 32'h0, 1, 1);
		// counting
		add_row(1, op_snapshot, addr_tx_sop_lo, 32'h0, 5, 6, 32'h0, 1, 1);
		// carry from low into high word
		add_row(0, op_write, addr_tx_pkt_lo, 32'hffff_fffe, 0, 0, 32'h0, 0, 0);
		add_row(0, op_snapshot, addr_tx_sop_lo, 32'h0, 3, 0, 32'h0, 0, 0);
		add_row(0, op_read, addr_tx_pkt_lo, 32'h0, 0, 0, 32'h1, 0, 0);
		add_row(1, op_read, addr_tx_pkt_hi, 32'h0, 0, 0, 32'h1, 0, 0);
		// saturation
		add_row(0, op_write, addr_rx_crc_err_hi, 32'hffff_ffff, 0, 0, 32'h0, 0, 0);
		add_row(0, op_write, addr_rx_crc_err_lo, 32'hffff_ffff, 0, 0, 32'h0, 0, 0);
		add_row(1, op_snapshot, addr_tx_sop_lo, 32'h0, 0, 4, 32'h0, 0, 0);
		add_row(0, op_read, addr_rx_crc_err_lo, 32'h0, 0, 0, 32'hffff_ffff, 0, 0);
		add_row(0, op_read, addr_rx_crc_err_hi, 32'h0, 0, 0, 32'hffff_ffff, 0, 0);
		// shadows hold until the next snapshot
		add_row(1, op_read, addr_rx_sop_lo, 32'h0, 0, 3, 32'h0, 1, 0);
		add_row(0, op_snapshot, addr_tx_sop_lo, 32'h0, 2, 0, 32'h0, 1, 1);
	endtask

	initial begin
		row_t        r;
		logic [31:0] got;
		int          steps;
		arst_n     = 1'b0;
		mgmt_req   = 1'b0;
		mgmt_op    = op_read;
		mgmt_addr  = addr_tx_sop_lo;
		mgmt_wdata = '0;
		dbg_req    = 1'b0;
		dbg_op     = op_read;
		dbg_addr   = addr_tx_sop_lo;
		dbg_wdata  = '0;
		{tx_sop, tx_eop, tx_pkt} = 3'b000;
		{rx_sop, rx_eop, rx_pkt, rx_crc_ok, rx_crc_err} = '0;
		live   = '{default: '0};
		shadow = '{default: '0};
		build_table();
		// every sweep adds sixteen reads, the shared bus test two more
		steps = rows.size() + 2;
		foreach (rows[n]) begin
			steps += rows[n].sweep ? 16 : 0;
		end
		cycle_limit = steps * `TB_CYCLES_PER_ROW + `TB_TIMEOUT_MARGIN;
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;

		foreach (rows[n]) begin
			r = rows[n];
			drive_events(r.n_tx, r.n_rx);
			run_transaction(r.host, r.op, r.addr, r.wdata, got);
			if (r.op == op_write) begin
				model_write(r.addr, r.wdata);
			end
			if (r.op == op_snapshot) begin
				shadow = live;
			end
			if (r.op == op_read) begin
				check_word(r.addr, got, r.use_model ? shadow_word(r.addr) : r.exp);
			end
			if (r.sweep) begin
				for (int a = 0; a < 16; a++) begin
					run_transaction(r.host, op_read, cnt_addr_e'(a), '0, got);
					check_word(cnt_addr_e'(a), got, shadow_word(cnt_addr_e'(a)));
				end
			end
		end
		dual_read(addr_rx_pkt_lo, addr_tx_sop_lo);

		$display("checks done, errors: %0d", errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== pkt_stats_top.sv ====
// packet statistics top: two host ports, bus arbiter and counter bank
`timescale 1ns/1ns
`include "pkt_stats_params.svh"

module pkt_stats_top
	import pkt_stats_pkg::*;
(
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     mgmt_req,
	input  csr_op_e                  mgmt_op,
	input  cnt_addr_e                mgmt_addr,
	input  logic [`CSR_DATA_W-1:0]   mgmt_wdata,
	output logic                     mgmt_ack,
	output logic [`CSR_DATA_W-1:0]   mgmt_rdata,
	input  logic                     dbg_req,
	input  csr_op_e                  dbg_op,
	input  cnt_addr_e                dbg_addr,
	input  logic [`CSR_DATA_W-1:0]   dbg_wdata,
	output logic                     dbg_ack,
	output logic [`CSR_DATA_W-1:0]   dbg_rdata,
	input  logic                     tx_sop,
	input  logic                     tx_eop,
	input  logic                     tx_pkt,
	input  logic [`NUM_RX_LANES-1:0] rx_sop,
	input  logic [`NUM_RX_LANES-1:0] rx_eop,
	input  logic [`NUM_RX_LANES-1:0] rx_pkt,
	input  logic [`NUM_RX_LANES-1:0] rx_crc_ok,
	input  logic [`NUM_RX_LANES-1:0] rx_crc_err
);

	// host ports to arbiter
	logic                   mgmt_bus_req;
	csr_op_e                mgmt_bus_op;
	cnt_addr_e              mgmt_bus_addr;
	logic [`CSR_DATA_W-1:0] mgmt_bus_wdata;
	logic                   gnt_mgmt;
	logic                   dbg_bus_req;
	csr_op_e                dbg_bus_op;
	cnt_addr_e              dbg_bus_addr;
	logic [`CSR_DATA_W-1:0] dbg_bus_wdata;
	logic                   gnt_dbg;

	// arbiter to counter bank
	logic                   cmd_valid;
	csr_op_e                cmd_op;
	cnt_addr_e              cmd_addr;
	logic [`CSR_DATA_W-1:0] cmd_wdata;
	logic [`CSR_DATA_W-1:0] rd_data;

	csr_host_port #(.DATA_W(`CSR_DATA_W)) u_port_mgmt (
		.clk       (clk),
		.arst_n    (arst_n),
		.h_req     (mgmt_req),
		.h_op      (mgmt_op),
		.h_addr    (mgmt_addr),
		.h_wdata   (mgmt_wdata),
		.h_ack     (mgmt_ack),
		.h_rdata   (mgmt_rdata),
		.bus_req   (mgmt_bus_req),
		.bus_op    (mgmt_bus_op),
		.bus_addr  (mgmt_bus_addr),
		.bus_wdata (mgmt_bus_wdata),
		.bus_gnt   (gnt_mgmt),
		.rd_data   (rd_data)
	);

	csr_host_port #(.DATA_W(`CSR_DATA_W)) u_port_dbg (
		.clk       (clk),
		.arst_n    (arst_n),
		.h_req     (dbg_req),
		.h_op      (dbg_op),
		.h_addr    (dbg_addr),
		.h_wdata   (dbg_wdata),
		.h_ack     (dbg_ack),
		.h_rdata   (dbg_rdata),
		.bus_req   (dbg_bus_req),
		.bus_op    (dbg_bus_op),
		.bus_addr  (dbg_bus_addr),
		.bus_wdata (dbg_bus_wdata),
		.bus_gnt   (gnt_dbg),
		.rd_data   (rd_data)
	);

	csr_bus_arbiter #(.DATA_W(`CSR_DATA_W)) u_arb (
		.clk        (clk),
		.arst_n     (arst_n),
		.req_mgmt   (mgmt_bus_req),
		.req_dbg    (dbg_bus_req),
		.op_mgmt    (mgmt_bus_op),
		.op_dbg     (dbg_bus_op),
		.addr_mgmt  (mgmt_bus_addr),
		.addr_dbg   (dbg_bus_addr),
		.wdata_mgmt (mgmt_bus_wdata),
		.wdata_dbg  (dbg_bus_wdata),
		.gnt_mgmt   (gnt_mgmt),
		.gnt_dbg    (gnt_dbg),
		.cmd_valid  (cmd_valid),
		.cmd_op     (cmd_op),
		.cmd_addr   (cmd_addr),
		.cmd_wdata  (cmd_wdata)
	);

	pkt_event_counters u_counters (
		.clk        (clk),
		.arst_n     (arst_n),
		.tx_sop     (tx_sop),
		.tx_eop     (tx_eop),
		.tx_pkt     (tx_pkt),
		.rx_sop     (rx_sop),
		.rx_eop     (rx_eop),
		.rx_pkt     (rx_pkt),
		.rx_crc_ok  (rx_crc_ok),
		.rx_crc_err (rx_crc_err),
		.cmd_valid  (cmd_valid),
		.cmd_op     (cmd_op),
		.cmd_addr   (cmd_addr),
		.cmd_wdata  (cmd_wdata),
		.rd_data    (rd_data)
	);

endmodule

// ==== sim.f ====
+incdir+.
pkt_stats_pkg.sv
pkt_event_counters.sv
csr_host_port.sv
csr_bus_arbiter.sv
pkt_stats_top.sv
pkt_stats_assert.sv
pkt_stats_tb.sv
